// ==== common/avalon_pkg.sv ====
// Avalon-MM bus widths and fixed transfer constants
// Shared by the DDR3 master, the top level and the memory model
`default_nettype none

package avalon_pkg;

    // Bus widths
    localparam int AVM_DATA_W  = 32;   // One word per beat
    localparam int AVM_ADDR_W  = 32;   // Byte address
    localparam int AVM_BE_W    = 4;    // One enable per data byte
    localparam int AVM_BURST_W = 11;   // Controller burstcount port

    // Byte step from one word to the next
    localparam int AVM_WORD_BYTES = 4;

endpackage

`default_nettype wire

// ==== common/mem_cmd_pkg.sv ====
// Command definitions for the memory-access subsystem
// Opcodes, command field widths and command queue sizing
`default_nettype none

package mem_cmd_pkg;

    // Client command opcodes
    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,   // Single word write
        OP_READ  = 2'd1,   // Single word read
        OP_FILL  = 2'd2    // Incrementing pattern over a run of words
    } mem_op_t;

    // Fill word count, a count of 0 runs one word
    localparam int FILL_LEN_W = 8;

    // Command queue
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int CMD_FIFO_AW    = 2;   // Pointer bits for CMD_FIFO_DEPTH entries

endpackage

`default_nettype wire

// ==== avalon_master/avalon_ddr3_interface.sv ====
// Avalon-MM master toward the DDR3 controller
// One single-beat read or write at a time, all byte lanes enabled
`default_nettype none

module avalon_ddr3_interface
    import avalon_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // Avalon master port
    output logic                   avm_m0_read,
    output logic                   avm_m0_write,
    output logic [AVM_DATA_W-1:0]  avm_m0_writedata,
    output logic [AVM_ADDR_W-1:0]  avm_m0_address,
    input  logic [AVM_DATA_W-1:0]  avm_m0_readdata,
    input  logic                   avm_m0_readdatavalid,
    output logic [AVM_BE_W-1:0]    avm_m0_byteenable,
    input  logic                   avm_m0_waitrequest,
    output logic [AVM_BURST_W-1:0] avm_m0_burstcount,

    // Client side, address held by the client until completion
    input  logic [AVM_ADDR_W-1:0]  sdram_address,
    input  logic                   rd_en,              // One cycle pulse
    output logic [AVM_DATA_W-1:0]  read_data,          // Valid after read_complete
    input  logic                   wr_en,              // One cycle pulse
    input  logic [AVM_DATA_W-1:0]  write_data_input,
    output logic                   write_complete,
    output logic                   read_complete
);

    typedef enum logic [1:0] {
        INIT,
        WRITE_START,
        READ_START,
        READ_END
    } state_t;

    state_t cur_state;
    state_t next_state;

    logic [AVM_DATA_W-1:0] write_data;   // Write word taken at the enable pulse

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_state <= INIT;
        end else begin
            cur_state <= next_state;
        end
    end

    // Data registers
    always_ff @(posedge clk) begin
        if (cur_state == INIT && wr_en) begin
            write_data <= write_data_input;
        end
        if (cur_state == READ_END && avm_m0_readdatavalid) begin
            read_data <= avm_m0_readdata;   // Shows up the cycle after read_complete
        end
    end

    always_comb begin
        next_state     = cur_state;
        write_complete = 1'b0;
        read_complete  = 1'b0;

        // Bus idle by default
        avm_m0_read       = 1'b0;
        avm_m0_write      = 1'b0;
        avm_m0_address    = '0;
        avm_m0_writedata  = '0;
        avm_m0_byteenable = '0;
        avm_m0_burstcount = '0;

        case (cur_state)
            INIT: begin
                // Write wins when both enables arrive together
                if (wr_en) begin
                    next_state = WRITE_START;
                end else if (rd_en) begin
                    next_state = READ_START;
                end
            end

            WRITE_START: begin
                // Request stays up through the accepting cycle
                avm_m0_write      = 1'b1;
                avm_m0_address    = sdram_address;
                avm_m0_writedata  = write_data;
                avm_m0_byteenable = '1;
                avm_m0_burstcount = AVM_BURST_W'(1);
                if (!avm_m0_waitrequest) begin
                    write_complete = 1'b1;   // Accepted, nothing more to wait for
                    next_state     = INIT;
                end
            end

            READ_START: begin
                avm_m0_read       = 1'b1;
                avm_m0_address    = sdram_address;
                avm_m0_byteenable = '1;
                avm_m0_burstcount = AVM_BURST_W'(1);
                if (!avm_m0_waitrequest) begin
                    next_state = READ_END;
                end
            end

            READ_END: begin
                // Latency set by the controller
                if (avm_m0_readdatavalid) begin
                    read_complete = 1'b1;
                    next_state    = INIT;
                end
            end

            default: begin
                next_state = INIT;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cmd_fifo.sv ====
// Command queue between the client port and the sequencer
// Circular buffer, valid/ready on both sides, head shown combinationally
`default_nettype none

module cmd_fifo
    import avalon_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // Write side
    input  logic                  in_valid,
    output logic                  in_ready,
    input  mem_op_t               in_op,
    input  logic [AVM_ADDR_W-1:0] in_addr,
    input  logic [AVM_DATA_W-1:0] in_data,
    input  logic [FILL_LEN_W-1:0] in_len,
    // Read side
    output logic                  out_valid,
    input  logic                  out_ready,
    output mem_op_t               out_op,
    output logic [AVM_ADDR_W-1:0] out_addr,
    output logic [AVM_DATA_W-1:0] out_data,
    output logic [FILL_LEN_W-1:0] out_len
);

    // Entry storage
    mem_op_t               op_mem   [CMD_FIFO_DEPTH];
    logic [AVM_ADDR_W-1:0] addr_mem [CMD_FIFO_DEPTH];
    logic [AVM_DATA_W-1:0] data_mem [CMD_FIFO_DEPTH];
    logic [FILL_LEN_W-1:0] len_mem  [CMD_FIFO_DEPTH];

    logic [CMD_FIFO_AW-1:0] wr_ptr;
    logic [CMD_FIFO_AW-1:0] rd_ptr;
    logic [CMD_FIFO_AW:0]   count;    // One extra bit to tell full from empty
    logic                   push;
    logic                   pop;

    assign in_ready  = (count != (CMD_FIFO_AW + 1)'(CMD_FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head entry
    assign out_op   = op_mem[rd_ptr];
    assign out_addr = addr_mem[rd_ptr];
    assign out_data = data_mem[rd_ptr];
    assign out_len  = len_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]   <= in_op;
            addr_mem[wr_ptr] <= in_addr;
            data_mem[wr_ptr] <= in_data;
            len_mem[wr_ptr]  <= in_len;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at the depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_cmd_sequencer.sv ====
// Command sequencer
// Turns each queued command into word transfers for the Avalon master
// and returns one response per command
`default_nettype none

module mem_cmd_sequencer
    import avalon_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // Queue head
    input  logic                  q_valid,
    output logic                  q_ready,
    input  mem_op_t               q_op,
    input  logic [AVM_ADDR_W-1:0] q_addr,
    input  logic [AVM_DATA_W-1:0] q_data,
    input  logic [FILL_LEN_W-1:0] q_len,
    // Avalon master
    output logic [AVM_ADDR_W-1:0] sdram_address,
    output logic [AVM_DATA_W-1:0] write_data_input,
    output logic                  wr_en,
    output logic                  rd_en,
    input  logic                  write_complete,
    input  logic                  read_complete,
    input  logic [AVM_DATA_W-1:0] read_data,
    // Response port
    output logic                  resp_valid,
    input  logic                  resp_ready,
    output mem_op_t               resp_op,
    output logic [AVM_DATA_W-1:0] resp_data
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,       // Enable pulse to the master
        WAIT_DONE,   // Transfer in flight
        CAPTURE,     // Read word available from the master
        RESPOND      // Response held until taken
    } state_t;

    state_t state;
    state_t next_state;

    mem_op_t               cur_op;
    logic [AVM_ADDR_W-1:0] cur_addr;
    logic [AVM_DATA_W-1:0] cur_data;
    logic [FILL_LEN_W-1:0] words_left;
    logic [AVM_DATA_W-1:0] resp_data_q;
    logic                  take;
    logic                  last_word;

    // Ready only offered to a waiting command
    assign q_ready = (state == IDLE) && q_valid;
    assign take    = q_valid && q_ready;

    // Write and read are always one word
    assign last_word = (cur_op != OP_FILL) || (words_left == FILL_LEN_W'(1));

    assign sdram_address    = cur_addr;   // Held until completion
    assign write_data_input = cur_data;
    assign wr_en = (state == ISSUE) && (cur_op != OP_READ);
    assign rd_en = (state == ISSUE) && (cur_op == OP_READ);

    // Read response goes out in CAPTURE straight from the master's register
    assign resp_valid = (state == CAPTURE) || (state == RESPOND);
    assign resp_op    = cur_op;
    assign resp_data  = (state == CAPTURE) ? read_data : resp_data_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (take) next_state = ISSUE;
            ISSUE:     next_state = WAIT_DONE;
            WAIT_DONE: begin
                if (read_complete) begin
                    next_state = CAPTURE;
                end else if (write_complete) begin
                    next_state = last_word ? RESPOND : ISSUE;   // Next fill word
                end
            end
            CAPTURE:   next_state = resp_ready ? IDLE : RESPOND;
            RESPOND:   if (resp_ready) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // Command and response registers
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (take) begin
                    cur_op     <= q_op;
                    cur_addr   <= q_addr;
                    cur_data   <= q_data;
                    words_left <= (q_len == '0) ? FILL_LEN_W'(1) : q_len;
                end
            end
            WAIT_DONE: begin
                if (write_complete) begin
                    if (last_word) begin
                        resp_data_q <= '0;   // Write and fill answer zero
                    end else begin
                        cur_addr   <= cur_addr + AVM_ADDR_W'(AVM_WORD_BYTES);
                        cur_data   <= cur_data + 1'b1;
                        words_left <= words_left - 1'b1;
                    end
                end
            end
            CAPTURE:  resp_data_q <= read_data;   // Kept if the client stalls
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/ddr_access_top.sv ====
// Memory-access subsystem top level
// Command FIFO, sequencer and Avalon master toward the DDR3 controller
`default_nettype none

module ddr_access_top
    import avalon_pkg::*;
    import mem_cmd_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    // Command port
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  mem_op_t                cmd_op,
    input  logic [AVM_ADDR_W-1:0]  cmd_addr,
    input  logic [AVM_DATA_W-1:0]  cmd_data,
    input  logic [FILL_LEN_W-1:0]  cmd_len,
    // Response port
    output logic                   resp_valid,
    input  logic                   resp_ready,
    output mem_op_t                resp_op,
    output logic [AVM_DATA_W-1:0]  resp_data,
    // Avalon master port
    output logic                   avm_m0_read,
    output logic                   avm_m0_write,
    output logic [AVM_DATA_W-1:0]  avm_m0_writedata,
    output logic [AVM_ADDR_W-1:0]  avm_m0_address,
    input  logic [AVM_DATA_W-1:0]  avm_m0_readdata,
    input  logic                   avm_m0_readdatavalid,
    output logic [AVM_BE_W-1:0]    avm_m0_byteenable,
    input  logic                   avm_m0_waitrequest,
    output logic [AVM_BURST_W-1:0] avm_m0_burstcount
);

    // FIFO to sequencer
    logic                  q_valid;
    logic                  q_ready;
    mem_op_t               q_op;
    logic [AVM_ADDR_W-1:0] q_addr;
    logic [AVM_DATA_W-1:0] q_data;
    logic [FILL_LEN_W-1:0] q_len;

    // Sequencer to master
    logic [AVM_ADDR_W-1:0] sdram_address;
    logic [AVM_DATA_W-1:0] write_data_input;
    logic [AVM_DATA_W-1:0] read_data;
    logic                  wr_en;
    logic                  rd_en;
    logic                  write_complete;
    logic                  read_complete;

    cmd_fifo u_cmd_fifo (
        .clk(clk), .reset(reset),
        .in_valid(cmd_valid), .in_ready(cmd_ready), .in_op(cmd_op),
        .in_addr(cmd_addr), .in_data(cmd_data), .in_len(cmd_len),
        .out_valid(q_valid), .out_ready(q_ready), .out_op(q_op),
        .out_addr(q_addr), .out_data(q_data), .out_len(q_len)
    );

    mem_cmd_sequencer u_sequencer (
        .clk(clk), .reset(reset),
        .q_valid(q_valid), .q_ready(q_ready), .q_op(q_op),
        .q_addr(q_addr), .q_data(q_data), .q_len(q_len),
        .sdram_address(sdram_address), .write_data_input(write_data_input),
        .wr_en(wr_en), .rd_en(rd_en),
        .write_complete(write_complete), .read_complete(read_complete),
        .read_data(read_data),
        .resp_valid(resp_valid), .resp_ready(resp_ready),
        .resp_op(resp_op), .resp_data(resp_data)
    );

    avalon_ddr3_interface u_avalon_master (
        .clk(clk), .reset(reset),
        .avm_m0_read(avm_m0_read), .avm_m0_write(avm_m0_write),
        .avm_m0_writedata(avm_m0_writedata), .avm_m0_address(avm_m0_address),
        .avm_m0_readdata(avm_m0_readdata), .avm_m0_readdatavalid(avm_m0_readdatavalid),
        .avm_m0_byteenable(avm_m0_byteenable), .avm_m0_waitrequest(avm_m0_waitrequest),
        .avm_m0_burstcount(avm_m0_burstcount),
        .sdram_address(sdram_address), .rd_en(rd_en), .read_data(read_data),
        .wr_en(wr_en), .write_data_input(write_data_input),
        .write_complete(write_complete), .read_complete(read_complete)
    );

endmodule

`default_nettype wire

// ==== test/avalon_mem_model.sv ====
// Behavioral Avalon-MM slave memory standing in for the DDR3 controller
// Random waitrequest stalls and read latency, one read outstanding at a time
`default_nettype none

module avalon_mem_model
    import avalon_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  read,
    input  logic                  write,
    input  logic [AVM_ADDR_W-1:0] address,
    input  logic [AVM_DATA_W-1:0] writedata,
    output logic                  waitrequest,
    output logic [AVM_DATA_W-1:0] readdata,
    output logic                  readdatavalid
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          WORDS = 256;
    localparam logic [31:0] SEED  = 32'h1668;

    logic [AVM_DATA_W-1:0] mem [WORDS];
    logic [31:0]           rng;
    logic [31:0]           draw;           // Next random word
    logic [1:0]            stall_left;     // Waitrequest cycles still owed
    logic [1:0]            latency_left;   // Cycles until read data
    logic                  pending;        // Read accepted, data not yet returned
    logic [7:0]            read_idx;
    logic                  accept;

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign draw        = xorshift_step(rng);
    assign waitrequest = pending || (stall_left != 2'd0);   // No new request during a read
    assign accept      = (read || write) && !waitrequest;

    always @(posedge clk) begin
        if (reset) begin
            rng           <= SEED;
            stall_left    <= 2'd0;
            latency_left  <= 2'd0;
            pending       <= 1'b0;
            read_idx      <= 8'd0;
            readdata      <= '0;
            readdatavalid <= 1'b0;
            // Pattern built from the whole word index
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= 32'hDD00_0000 | (32'(i) << 8) | 32'(i);
            end
        end else begin
            readdatavalid <= 1'b0;
            if ((read || write) && stall_left != 2'd0) begin
                stall_left <= stall_left - 2'd1;   // Stall only counts against a request
            end
            if (accept) begin
                rng          <= draw;
                stall_left   <= draw[1:0];   // Stall for the next request
                latency_left <= draw[3:2];   // 1 to 4 cycles of read latency
                if (write) begin
                    mem[address[9:2]] <= writedata;
                end else begin
                    pending  <= 1'b1;
                    read_idx <= address[9:2];
                end
            end
            if (pending) begin
                if (latency_left == 2'd0) begin
                    readdata      <= mem[read_idx];
                    readdatavalid <= 1'b1;
                    pending       <= 1'b0;
                end else begin
                    latency_left <= latency_left - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_ddr_access.sv ====
// Testbench for the memory-access subsystem
// Directed command tests against a behavioral Avalon memory with a shadow copy
`default_nettype none

module tb_ddr_access
    import avalon_pkg::*;
    import mem_cmd_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MEM_WORDS      = 256;
    localparam int          TIMEOUT_CYCLES = 20000;   // Roughly ten times the full run
    localparam logic [31:0] SEED           = 32'h1668;

    logic clk;
    logic reset;
    logic cmd_valid, cmd_ready, resp_valid, resp_ready;
    mem_op_t cmd_op, resp_op;
    logic [AVM_ADDR_W-1:0] cmd_addr, avm_m0_address;
    logic [AVM_DATA_W-1:0] cmd_data, resp_data, avm_m0_writedata, avm_m0_readdata;
    logic [FILL_LEN_W-1:0] cmd_len;
    logic avm_m0_read, avm_m0_write, avm_m0_waitrequest, avm_m0_readdatavalid;
    logic [AVM_BE_W-1:0] avm_m0_byteenable;
    logic [AVM_BURST_W-1:0] avm_m0_burstcount;

    logic [31:0] shadow [MEM_WORDS];   // Expected memory contents
    logic [31:0] rng;
    int          cycle_count = 0;

    ddr_access_top UUT (.*);

    avalon_mem_model mem_model (
        .clk(clk), .reset(reset),
        .read(avm_m0_read), .write(avm_m0_write),
        .address(avm_m0_address), .writedata(avm_m0_writedata),
        .waitrequest(avm_m0_waitrequest), .readdata(avm_m0_readdata),
        .readdatavalid(avm_m0_readdatavalid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift_next(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h expected 0x%h", name, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Single beat, all lanes, on every request
    always @(negedge clk) begin
        if (!reset && (avm_m0_read || avm_m0_write)) begin
            check("avm_m0_byteenable", 32'(avm_m0_byteenable), 32'hF);
            check("avm_m0_burstcount", 32'(avm_m0_burstcount), 32'h1);
        end
    end

    // Tasks below start and end just after a falling edge
    task automatic send_cmd(input mem_op_t op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [7:0] len);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
        cmd_len   = len;
        while (!cmd_ready) @(negedge clk);
        @(negedge clk);   // Taken on the rising edge in between
        cmd_valid = 1'b0;
    endtask

    task automatic get_response(output mem_op_t op, output logic [31:0] data);
        resp_ready = 1'b1;
        while (!resp_valid) @(negedge clk);
        op   = resp_op;
        data = resp_data;
        @(negedge clk);
        resp_ready = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        mem_op_t     op;
        logic [31:0] rdata;
        send_cmd(OP_WRITE, addr, data, 8'd0);
        get_response(op, rdata);
        check("resp_op", 32'(op), 32'(OP_WRITE));
        check("resp_data", rdata, 32'h0);
        shadow[addr[9:2]] = data;
    endtask

    task automatic read_word(input logic [31:0] addr);
        mem_op_t     op;
        logic [31:0] rdata;
        send_cmd(OP_READ, addr, 32'h0, 8'd0);
        get_response(op, rdata);
        check("resp_op", 32'(op), 32'(OP_READ));
        check("resp_data", rdata, shadow[addr[9:2]]);
    endtask

    task automatic test_reset_state();
        check("resp_valid", 32'(resp_valid), 32'h0);
        check("avm_m0_read", 32'(avm_m0_read), 32'h0);
        check("avm_m0_write", 32'(avm_m0_write), 32'h0);
        check("cmd_ready", 32'(cmd_ready), 32'h1);
    endtask

    task automatic test_write_read();
        write_word(32'h0000_0010, 32'hCAFE_0123);
        read_word(32'h0000_0010);
    endtask

    task automatic test_fill();
        mem_op_t     op;
        logic [31:0] rdata;
        send_cmd(OP_FILL, 32'h0000_0040, 32'h1000_0000, 8'd6);
        get_response(op, rdata);
        check("resp_op", 32'(op), 32'(OP_FILL));
        check("resp_data", rdata, 32'h0);
        repeat (10) begin   // No second response for the same fill
            @(negedge clk);
            check("resp_valid", 32'(resp_valid), 32'h0);
        end
        for (int i = 0; i < 6; i++) begin
            shadow[16 + i] = 32'h1000_0000 + 32'(i);
        end
        for (int i = 0; i < 6; i++) begin
            read_word(32'h0000_0040 + 32'(4 * i));
        end
    endtask

    task automatic test_random();
        logic [31:0] addr;
        for (int n = 0; n < 40; n++) begin
            rng  = xorshift_next(rng);
            addr = {22'd0, rng[7:0], 2'b00};
            rng  = xorshift_next(rng);
            write_word(addr, rng);
            rng  = xorshift_next(rng);
            read_word({22'd0, rng[7:0], 2'b00});   // Often a word never written
        end
    endtask

    task automatic test_backpressure();
        mem_op_t     exp_op [$];
        logic [31:0] exp_data [$];
        logic [31:0] addr;
        mem_op_t     op;
        logic [31:0] rdata;
        int          sent;
        sent = 0;
        // Write then read back pairs until the queue stops taking commands
        while (cmd_ready && sent < 8) begin
            addr      = 32'h0000_0200 + 32'(4 * (sent / 2));
            cmd_valid = 1'b1;
            cmd_addr  = addr;
            cmd_len   = 8'd0;
            if (sent % 2 == 0) begin
                cmd_op  = OP_WRITE;
                cmd_data = 32'hB000_0000 + 32'(sent);
                shadow[addr[9:2]] = cmd_data;
                exp_op.push_back(OP_WRITE);
                exp_data.push_back(32'h0);
            end else begin
                cmd_op  = OP_READ;
                exp_op.push_back(OP_READ);
                exp_data.push_back(shadow[addr[9:2]]);
            end
            @(negedge clk);
            sent++;
        end
        cmd_valid = 1'b0;
        repeat (10) @(negedge clk);
        check("cmd_ready", 32'(cmd_ready), 32'h0);
        check("accepted commands", 32'(sent), 32'(CMD_FIFO_DEPTH + 1));
        while (exp_op.size() > 0) begin   // Drain in command order
            get_response(op, rdata);
            check("resp_op", 32'(op), 32'(exp_op.pop_front()));
            check("resp_data", rdata, exp_data.pop_front());
        end
    endtask

    initial begin
        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = OP_WRITE;
        cmd_addr   = '0;
        cmd_data   = '0;
        cmd_len    = '0;
        resp_ready = 1'b0;
        rng        = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = 32'hDD00_0000 | (32'(i) << 8) | 32'(i);   // Same as the model
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        test_reset_state();
        test_write_read();
        test_fill();
        test_random();
        test_backpressure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== Makefile ====
# Verilator simulation of the DDR access subsystem

TOP = tb_ddr_access

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f ddr_access.f \
		--top-module $(TOP) -Mdir obj_dir

# Pass or fail comes from the log
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== ddr_access.f ====
common/avalon_pkg.sv
common/mem_cmd_pkg.sv
avalon_master/avalon_ddr3_interface.sv
source/cmd_fifo.sv
source/mem_cmd_sequencer.sv
source/ddr_access_top.sv
test/avalon_mem_model.sv
test/tb_ddr_access.sv
